// File: verilog/mmu_pkg.sv
// Shared widths, PTE layout, exception causes and credit settings for the
// Sv39 load/store MMU. Every design file refers to these by scoped name
// (mmu_pkg::NAME) instead of importing the package.

package mmu_pkg;

  // ----------------------------------------
  // address and page geometry
  // ----------------------------------------
  localparam int unsigned VLEN          = 39;
  localparam int unsigned PLEN          = 56;
  localparam int unsigned PPNW          = 44;
  localparam int unsigned PTE_W         = 64;
  localparam int unsigned PAGE_OFFSET_W = 12;
  localparam int unsigned VPN_W         = 9;
  localparam int unsigned PT_LEVELS     = 3;
  localparam int unsigned TLB_ENTRIES   = 4;

  // memory port credits held after reset
  localparam int unsigned MEM_CREDITS = 2;
  localparam int unsigned CREDIT_W    = $clog2(MEM_CREDITS + 1);

  // ----------------------------------------
  // exceptions and privilege
  // ----------------------------------------
  localparam int unsigned CAUSE_W = 6;
  localparam logic [CAUSE_W-1:0] CAUSE_LOAD_PAGE_FAULT  = 6'd13;
  localparam logic [CAUSE_W-1:0] CAUSE_STORE_PAGE_FAULT = 6'd15;

  typedef logic [1:0] priv_lvl_t;

  localparam priv_lvl_t PRIV_U = 2'b00;
  localparam priv_lvl_t PRIV_S = 2'b01;

  // Sv39 page table entry, msb first
  typedef struct packed {
    logic [PTE_W-PPNW-11:0] reserved;
    logic [PPNW-1:0]        ppn;
    logic [1:0]             rsw;
    logic                   d;
    logic                   a;
    logic                   g;
    logic                   u;
    logic                   x;
    logic                   w;
    logic                   r;
    logic                   v;
  } pte_t;

  // fill request from the walker into the TLB
  typedef struct packed {
    logic                 valid;
    logic [3*VPN_W-1:0]   vpn;
    logic                 is_2m;
    logic                 is_1g;
    pte_t                 pte;
  } tlb_update_t;

endpackage

// File: verilog/mmu_credit_counter.sv
// Credit counter for the walker's memory read port.
// Starts full after reset, loses one credit per issued request and regains
// one per credit pulse from memory. Requests may only go out while the
// count is nonzero.

`timescale 1ns/1ps

module mmu_credit_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic consume_i,
  input  logic return_i,
  output logic credit_avail_o
);

  logic [mmu_pkg::CREDIT_W-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= mmu_pkg::CREDIT_W'(mmu_pkg::MEM_CREDITS);
    end else if (consume_i && !return_i) begin
      count_q <= count_q - 1'b1;
    end else if (return_i && !consume_i) begin
      count_q <= count_q + 1'b1;
    end
    // consume and return together leave the count unchanged
  end

  assign credit_avail_o = (count_q != '0);

endmodule

// File: verilog/mmu_tlb.sv
// Fully associative data TLB for Sv39 translation.
// Lookup is combinational on the incoming vaddr; 2M and 1G entries compare
// fewer VPN slices. Fills from the walker go to a round-robin victim and,
// like a flush, take effect on the next clock edge.

`timescale 1ns/1ps

module mmu_tlb (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       flush_i,
  input  logic                       lu_access_i,
  input  logic [mmu_pkg::VLEN-1:0]   lu_vaddr_i,
  output logic                       lu_hit_o,
  output mmu_pkg::pte_t              lu_pte_o,
  output logic                       lu_is_2m_o,
  output logic                       lu_is_1g_o,
  input  mmu_pkg::tlb_update_t       update_i
);

  logic [mmu_pkg::TLB_ENTRIES-1:0] valid_q;
  logic [mmu_pkg::TLB_ENTRIES-1:0] is_2m_q;
  logic [mmu_pkg::TLB_ENTRIES-1:0] is_1g_q;
  logic [mmu_pkg::VPN_W-1:0]       vpn2_q [mmu_pkg::TLB_ENTRIES];
  logic [mmu_pkg::VPN_W-1:0]       vpn1_q [mmu_pkg::TLB_ENTRIES];
  logic [mmu_pkg::VPN_W-1:0]       vpn0_q [mmu_pkg::TLB_ENTRIES];
  mmu_pkg::pte_t                   pte_q  [mmu_pkg::TLB_ENTRIES];

  logic [$clog2(mmu_pkg::TLB_ENTRIES)-1:0] rr_ptr_q;
  logic [mmu_pkg::TLB_ENTRIES-1:0]         match;

  logic [mmu_pkg::VPN_W-1:0] lu_vpn2;
  logic [mmu_pkg::VPN_W-1:0] lu_vpn1;
  logic [mmu_pkg::VPN_W-1:0] lu_vpn0;

  assign lu_vpn2 = lu_vaddr_i[mmu_pkg::PAGE_OFFSET_W + 2*mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
  assign lu_vpn1 = lu_vaddr_i[mmu_pkg::PAGE_OFFSET_W + mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
  assign lu_vpn0 = lu_vaddr_i[mmu_pkg::PAGE_OFFSET_W +: mmu_pkg::VPN_W];

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
      // superpages ignore the low slices
      match[i] = valid_q[i] && (vpn2_q[i] == lu_vpn2)
                 && (is_1g_q[i] || (vpn1_q[i] == lu_vpn1))
                 && (is_1g_q[i] || is_2m_q[i] || (vpn0_q[i] == lu_vpn0));
    end
  end

  always_comb begin
    lu_hit_o   = 1'b0;
    lu_pte_o   = '0;
    lu_is_2m_o = 1'b0;
    lu_is_1g_o = 1'b0;
    for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
      if (lu_access_i && match[i]) begin
        lu_hit_o   = 1'b1;
        lu_pte_o   = pte_q[i];
        lu_is_2m_o = is_2m_q[i];
        lu_is_1g_o = is_1g_q[i];
      end
    end
  end

  // ----------------------------------------
  // fill and flush
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      rr_ptr_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[rr_ptr_q] <= 1'b1;
      rr_ptr_q          <= rr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      vpn2_q[rr_ptr_q]  <= update_i.vpn[2*mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
      vpn1_q[rr_ptr_q]  <= update_i.vpn[mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
      vpn0_q[rr_ptr_q]  <= update_i.vpn[0 +: mmu_pkg::VPN_W];
      is_2m_q[rr_ptr_q] <= update_i.is_2m;
      is_1g_q[rr_ptr_q] <= update_i.is_1g;
      pte_q[rr_ptr_q]   <= update_i.pte;
    end
  end

endmodule

// File: verilog/mmu_ptw.sv
// Sv39 page table walker for data TLB misses.
// A translated access that misses starts a walk at satp_ppn_i, level 2.
// Each level issues one PTE read on the credited memory port and waits for
// its response. A valid leaf fills the TLB; a bad PTE ends the walk with
// one cycle of ptw_error_o in PROPAGATE_ERROR.

`timescale 1ns/1ps

module mmu_ptw (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       en_translation_i,
  input  logic [mmu_pkg::PPNW-1:0]   satp_ppn_i,
  input  logic                       dtlb_access_i,
  input  logic                       dtlb_hit_i,
  input  logic [mmu_pkg::VLEN-1:0]   dtlb_vaddr_i,
  input  logic                       is_store_i,
  output logic                       mem_req_o,
  output logic [mmu_pkg::PLEN-1:0]   mem_addr_o,
  input  logic                       mem_rvalid_i,
  input  mmu_pkg::pte_t              mem_rdata_i,
  input  logic                       credit_avail_i,
  output logic                       ptw_active_o,
  output logic                       ptw_error_o,
  output logic [mmu_pkg::VLEN-1:0]   fault_vaddr_o,
  output mmu_pkg::tlb_update_t       update_o
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT_RESP, PROPAGATE_ERROR} state_e;

  state_e                     state_q, state_d;
  logic [1:0]                 level_q, level_d;
  logic [mmu_pkg::PPNW-1:0]   ptr_ppn_q, ptr_ppn_d;
  logic [mmu_pkg::VLEN-1:0]   vaddr_q, vaddr_d;
  logic                       store_q, store_d;

  logic                       fill_valid;
  logic                       is_leaf;
  logic                       misaligned;
  logic [mmu_pkg::VPN_W-1:0]  vpn_slice;

  assign is_leaf = mem_rdata_i.r | mem_rdata_i.x;

  // VPN slice and superpage alignment for the current level
  always_comb begin
    vpn_slice  = vaddr_q[mmu_pkg::PAGE_OFFSET_W +: mmu_pkg::VPN_W];
    misaligned = 1'b0;
    case (level_q)
      2'd2: begin
        vpn_slice  = vaddr_q[mmu_pkg::PAGE_OFFSET_W + 2*mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
        misaligned = (mem_rdata_i.ppn[2*mmu_pkg::VPN_W-1:0] != '0);
      end
      2'd1: begin
        vpn_slice  = vaddr_q[mmu_pkg::PAGE_OFFSET_W + mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
        misaligned = (mem_rdata_i.ppn[mmu_pkg::VPN_W-1:0] != '0);
      end
      default: ;
    endcase
  end

  // ----------------------------------------
  // walk FSM
  // ----------------------------------------
  always_comb begin
    state_d     = state_q;
    level_d     = level_q;
    ptr_ppn_d   = ptr_ppn_q;
    vaddr_d     = vaddr_q;
    store_d     = store_q;
    mem_req_o   = 1'b0;
    ptw_error_o = 1'b0;
    fill_valid  = 1'b0;
    case (state_q)
      IDLE: begin
        if (en_translation_i && dtlb_access_i && !dtlb_hit_i) begin
          state_d   = REQ;
          level_d   = 2'(mmu_pkg::PT_LEVELS - 1);
          ptr_ppn_d = satp_ppn_i;
          vaddr_d   = dtlb_vaddr_i;
          store_d   = is_store_i;
        end
      end
      REQ: begin
        // hold here until the port has a credit
        mem_req_o = credit_avail_i;
        if (credit_avail_i) begin
          state_d = WAIT_RESP;
        end
      end
      WAIT_RESP: begin
        if (mem_rvalid_i) begin
          if (!mem_rdata_i.v || (mem_rdata_i.w && !mem_rdata_i.r)) begin
            state_d = PROPAGATE_ERROR;
          end else if (is_leaf) begin
            // a/d are not updated in hardware, so a clean page faults on store
            if (misaligned || !mem_rdata_i.a || (store_q && !mem_rdata_i.d)) begin
              state_d = PROPAGATE_ERROR;
            end else begin
              fill_valid = 1'b1;
              state_d    = IDLE;
            end
          end else if (level_q == 2'd0) begin
            state_d = PROPAGATE_ERROR;
          end else begin
            level_d   = level_q - 1'b1;
            ptr_ppn_d = mem_rdata_i.ppn;
            state_d   = REQ;
          end
        end
      end
      PROPAGATE_ERROR: begin
        ptw_error_o = 1'b1;
        state_d     = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      level_q <= '0;
    end else begin
      state_q <= state_d;
      level_q <= level_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ptr_ppn_q <= ptr_ppn_d;
    vaddr_q   <= vaddr_d;
    store_q   <= store_d;
  end

  // PTE address is table ppn, then slice times 8
  assign mem_addr_o    = {ptr_ppn_q, vpn_slice, 3'b000};
  assign ptw_active_o  = (state_q != IDLE);
  assign fault_vaddr_o = vaddr_q;

  assign update_o = '{
    valid: fill_valid,
    vpn:   vaddr_q[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFFSET_W],
    is_2m: (level_q == 2'd1),
    is_1g: (level_q == 2'd2),
    pte:   mem_rdata_i
  };

endmodule

// File: verilog/mmu_lsu_check.sv
// Load/store side of the MMU, one registered stage after the TLB lookup.
// Builds the physical address from the registered PTE and page size, checks
// U/SUM and R/W/D permissions and selects the page fault cause. A walker
// error is reported in its own cycle with the walker's faulting vaddr.

`timescale 1ns/1ps

module mmu_lsu_check (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          en_translation_i,
  input  mmu_pkg::priv_lvl_t            priv_lvl_i,
  input  logic                          sum_i,
  input  logic                          lsu_req_i,
  input  logic [mmu_pkg::VLEN-1:0]      lsu_vaddr_i,
  input  logic                          lsu_is_store_i,
  input  logic                          tlb_hit_i,
  input  mmu_pkg::pte_t                 tlb_pte_i,
  input  logic                          tlb_is_2m_i,
  input  logic                          tlb_is_1g_i,
  input  logic                          ptw_active_i,
  input  logic                          ptw_error_i,
  input  logic [mmu_pkg::VLEN-1:0]      fault_vaddr_i,
  output logic                          lsu_dtlb_hit_o,
  output logic                          lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]      lsu_paddr_o,
  output logic                          lsu_exception_valid_o,
  output logic [mmu_pkg::CAUSE_W-1:0]   lsu_exception_cause_o,
  output logic [mmu_pkg::VLEN-1:0]      lsu_exception_tval_o
);

  logic                      req_q;
  logic                      hit_q;
  logic                      is_store_q;
  logic [mmu_pkg::VLEN-1:0]  vaddr_q;
  mmu_pkg::pte_t             pte_q;
  logic                      is_2m_q;
  logic                      is_1g_q;

  logic                      priv_err;
  logic                      perm_err;
  logic                      walk_err;

  // ----------------------------------------
  // request stage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      req_q <= lsu_req_i;
      hit_q <= tlb_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    is_store_q <= lsu_is_store_i;
    vaddr_q    <= lsu_vaddr_i;
    pte_q      <= tlb_pte_i;
    is_2m_q    <= tlb_is_2m_i;
    is_1g_q    <= tlb_is_1g_i;
  end

  // bypass is always ready
  assign lsu_dtlb_hit_o = en_translation_i ? tlb_hit_i : 1'b1;

  // ----------------------------------------
  // permission check
  // ----------------------------------------
  assign priv_err = ((priv_lvl_i == mmu_pkg::PRIV_S) && pte_q.u && !sum_i)
                    || ((priv_lvl_i == mmu_pkg::PRIV_U) && !pte_q.u);
  assign perm_err = is_store_q ? (priv_err || !pte_q.w || !pte_q.d)
                               : (priv_err || !pte_q.r);
  assign walk_err = ptw_active_i && ptw_error_i;

  always_comb begin
    lsu_paddr_o           = {{(mmu_pkg::PLEN - mmu_pkg::VLEN){1'b0}}, vaddr_q};
    lsu_valid_o           = req_q;
    lsu_exception_valid_o = 1'b0;
    lsu_exception_cause_o = is_store_q ? mmu_pkg::CAUSE_STORE_PAGE_FAULT
                                       : mmu_pkg::CAUSE_LOAD_PAGE_FAULT;
    lsu_exception_tval_o  = vaddr_q;
    if (en_translation_i) begin
      lsu_paddr_o = {pte_q.ppn, vaddr_q[mmu_pkg::PAGE_OFFSET_W-1:0]};
      // superpages take the low vpn slices from the vaddr
      if (is_2m_q) begin
        lsu_paddr_o[20:12] = vaddr_q[20:12];
      end
      if (is_1g_q) begin
        lsu_paddr_o[29:12] = vaddr_q[29:12];
      end
      lsu_valid_o           = (req_q && hit_q) || walk_err;
      lsu_exception_valid_o = (req_q && hit_q && perm_err) || walk_err;
      if (walk_err) begin
        lsu_exception_tval_o = fault_vaddr_i;
      end
    end
  end

endmodule

// File: verilog/mmu_top.sv
// Top level of the Sv39 load/store MMU.
// Connects the data TLB, the page table walker, the memory credit counter
// and the registered check stage. The LSU holds a missing request until
// lsu_valid_o; the walker reads PTEs over the credited memory port.

`timescale 1ns/1ps

module mmu_top (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // LSU request
  input  logic                          lsu_req_i,
  input  logic [mmu_pkg::VLEN-1:0]      lsu_vaddr_i,
  input  logic                          lsu_is_store_i,
  output logic                          lsu_dtlb_hit_o,
  output logic                          lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]      lsu_paddr_o,
  output logic                          lsu_exception_valid_o,
  output logic [mmu_pkg::CAUSE_W-1:0]   lsu_exception_cause_o,
  output logic [mmu_pkg::VLEN-1:0]      lsu_exception_tval_o,
  // control, held stable
  input  logic                          en_translation_i,
  input  mmu_pkg::priv_lvl_t            priv_lvl_i,
  input  logic                          sum_i,
  input  logic [mmu_pkg::PPNW-1:0]      satp_ppn_i,
  input  logic                          flush_tlb_i,
  // PTE read port
  output logic                          mem_req_o,
  output logic [mmu_pkg::PLEN-1:0]      mem_addr_o,
  input  logic                          mem_rvalid_i,
  input  mmu_pkg::pte_t                 mem_rdata_i,
  input  logic                          mem_credit_i
);

  logic                       dtlb_hit;
  mmu_pkg::pte_t              dtlb_pte;
  logic                       dtlb_is_2m;
  logic                       dtlb_is_1g;
  mmu_pkg::tlb_update_t       dtlb_update;
  logic                       ptw_active;
  logic                       ptw_error;
  logic [mmu_pkg::VLEN-1:0]   fault_vaddr;
  logic                       credit_avail;

  mmu_tlb i_dtlb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_tlb_i),
    .lu_access_i (lsu_req_i),
    .lu_vaddr_i  (lsu_vaddr_i),
    .lu_hit_o    (dtlb_hit),
    .lu_pte_o    (dtlb_pte),
    .lu_is_2m_o  (dtlb_is_2m),
    .lu_is_1g_o  (dtlb_is_1g),
    .update_i    (dtlb_update)
  );

  mmu_ptw i_ptw (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .en_translation_i (en_translation_i),
    .satp_ppn_i       (satp_ppn_i),
    .dtlb_access_i    (lsu_req_i),
    .dtlb_hit_i       (dtlb_hit),
    .dtlb_vaddr_i     (lsu_vaddr_i),
    .is_store_i       (lsu_is_store_i),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .credit_avail_i   (credit_avail),
    .ptw_active_o     (ptw_active),
    .ptw_error_o      (ptw_error),
    .fault_vaddr_o    (fault_vaddr),
    .update_o         (dtlb_update)
  );

  // one credit per issued request, one back per memory pulse
  mmu_credit_counter i_credit_counter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .consume_i      (mem_req_o),
    .return_i       (mem_credit_i),
    .credit_avail_o (credit_avail)
  );

  mmu_lsu_check i_lsu_check (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .en_translation_i      (en_translation_i),
    .priv_lvl_i            (priv_lvl_i),
    .sum_i                 (sum_i),
    .lsu_req_i             (lsu_req_i),
    .lsu_vaddr_i           (lsu_vaddr_i),
    .lsu_is_store_i        (lsu_is_store_i),
    .tlb_hit_i             (dtlb_hit),
    .tlb_pte_i             (dtlb_pte),
    .tlb_is_2m_i           (dtlb_is_2m),
    .tlb_is_1g_i           (dtlb_is_1g),
    .ptw_active_i          (ptw_active),
    .ptw_error_i           (ptw_error),
    .fault_vaddr_i         (fault_vaddr),
    .lsu_dtlb_hit_o        (lsu_dtlb_hit_o),
    .lsu_valid_o           (lsu_valid_o),
    .lsu_paddr_o           (lsu_paddr_o),
    .lsu_exception_valid_o (lsu_exception_valid_o),
    .lsu_exception_cause_o (lsu_exception_cause_o),
    .lsu_exception_tval_o  (lsu_exception_tval_o)
  );

endmodule

// File: tests/mmu_tb.sv
// Testbench for the Sv39 load/store MMU.
// Loads a page table image and request records from tests/mmu_tests.dat,
// serves PTE reads from a sparse memory model with random credit return
// and checks every lsu_valid_o result against the expected record values.

`timescale 1ns/1ps

module mmu_tb;

  localparam int RESET_CYCLES = 16;
  localparam int REC_WORDS    = 9;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          lsu_req;
  logic [mmu_pkg::VLEN-1:0]      lsu_vaddr;
  logic                          lsu_is_store;
  logic                          lsu_dtlb_hit;
  logic                          lsu_valid;
  logic [mmu_pkg::PLEN-1:0]      lsu_paddr;
  logic                          lsu_exc_valid;
  logic [mmu_pkg::CAUSE_W-1:0]   lsu_exc_cause;
  logic [mmu_pkg::VLEN-1:0]      lsu_exc_tval;
  logic                          en_translation;
  mmu_pkg::priv_lvl_t            priv_lvl;
  logic                          sum;
  logic [mmu_pkg::PPNW-1:0]      satp_ppn;
  logic                          flush_tlb;
  logic                          mem_req;
  logic [mmu_pkg::PLEN-1:0]      mem_addr;
  logic                          mem_rvalid;
  logic [63:0]                   mem_rdata;
  logic                          mem_credit;

  logic [63:0] vec [0:255];
  logic [63:0] pt_mem [logic [55:0]];

  integer seed = 32'he1fc_b3e9;
  int     num_records = 0;
  int     errors = 0;
  int     checks = 0;
  int     failed_tests = 0;
  int     mem_reads = 0;
  int     outstanding = 0;
  int     cycle = 0;
  int     last_resp_due = 0;
  int     last_credit_due = 0;
  logic   slow_credits = 1'b0;

  logic [55:0] resp_addr_q [$];
  int          resp_due_q  [$];
  int          credit_due_q [$];

  always #50 clk = ~clk;

  mmu_top i_dut (
    .clk_i                 (clk),
    .reset_i               (reset),
    .lsu_req_i             (lsu_req),
    .lsu_vaddr_i           (lsu_vaddr),
    .lsu_is_store_i        (lsu_is_store),
    .lsu_dtlb_hit_o        (lsu_dtlb_hit),
    .lsu_valid_o           (lsu_valid),
    .lsu_paddr_o           (lsu_paddr),
    .lsu_exception_valid_o (lsu_exc_valid),
    .lsu_exception_cause_o (lsu_exc_cause),
    .lsu_exception_tval_o  (lsu_exc_tval),
    .en_translation_i      (en_translation),
    .priv_lvl_i            (priv_lvl),
    .sum_i                 (sum),
    .satp_ppn_i            (satp_ppn),
    .flush_tlb_i           (flush_tlb),
    .mem_req_o             (mem_req),
    .mem_addr_o            (mem_addr),
    .mem_rvalid_i          (mem_rvalid),
    .mem_rdata_i           (mem_rdata),
    .mem_credit_i          (mem_credit)
  );

  // unmapped words read back as an invalid all-zero PTE
  function automatic logic [63:0] read_pte(input logic [55:0] addr);
    if (pt_mem.exists(addr)) begin
      return pt_mem[addr];
    end
    return 64'h0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    checks++;
    assert (exp == got) else begin
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, got);
      errors++;
    end
  endtask

  // ----------------------------------------
  // in-order memory model
  // ----------------------------------------
  always @(negedge clk) begin
    int delay;
    cycle++;
    mem_rvalid = 1'b0;
    mem_credit = 1'b0;
    if (!reset && mem_req) begin
      mem_reads++;
      outstanding++;
      delay = 2 + int'($unsigned($random(seed)) % 3);
      last_resp_due = (cycle + delay > last_resp_due) ? cycle + delay : last_resp_due + 1;
      resp_due_q.push_back(last_resp_due);
      resp_addr_q.push_back(mem_addr);
      // withheld credits come back much later
      delay = slow_credits ? 20 + int'($unsigned($random(seed)) % 16)
                           : 1 + int'($unsigned($random(seed)) % 4);
      last_credit_due = (cycle + delay > last_credit_due) ? cycle + delay
                                                          : last_credit_due + 1;
      credit_due_q.push_back(last_credit_due);
    end
    if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle) begin
      void'(resp_due_q.pop_front());
      mem_rdata  = read_pte(resp_addr_q.pop_front());
      mem_rvalid = 1'b1;
    end
    if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
      void'(credit_due_q.pop_front());
      mem_credit = 1'b1;
      outstanding--;
    end
    assert (outstanding <= mmu_pkg::MEM_CREDITS) else begin
      $display("more memory requests outstanding than credits allow: %0d at t=%0t",
               outstanding, $time);
      errors++;
    end
  end

  // ----------------------------------------
  // one request record
  // ----------------------------------------
  task automatic run_record(input int base, input int num);
    logic [63:0] mode;
    logic [63:0] vaddr;
    logic [63:0] exp_paddr;
    logic [63:0] exp_fault;
    logic [63:0] exp_cause;
    logic [63:0] exp_reads;
    logic        got_hit;
    logic        got_exc;
    logic [63:0] got_cause;
    logic [63:0] got_tval;
    logic [63:0] got_paddr;
    int          latency;
    int          reads_before;
    int          errors_before;
    mode      = vec[base];
    vaddr     = vec[base+4];
    exp_paddr = vec[base+5];
    exp_fault = vec[base+6];
    exp_cause = vec[base+7];
    exp_reads = vec[base+8];
    errors_before = errors;
    @(negedge clk);
    en_translation = mode[0];
    priv_lvl       = vec[base+1][1:0];
    sum            = vec[base+2][0];
    slow_credits   = mode[2];
    if (mode[1]) begin
      flush_tlb = 1'b1;
      @(negedge clk);
      flush_tlb = 1'b0;
    end
    @(negedge clk);
    reads_before = mem_reads;
    lsu_req      = 1'b1;
    lsu_vaddr    = vaddr[mmu_pkg::VLEN-1:0];
    lsu_is_store = vec[base+3][0];
    latency      = 0;
    // lookup result in the first request cycle
    #1;
    got_hit = lsu_dtlb_hit;
    // request stays up until the MMU answers
    do begin
      @(negedge clk);
      latency++;
    end while (!lsu_valid);
    got_exc   = lsu_exc_valid;
    got_cause = 64'(lsu_exc_cause);
    got_tval  = 64'(lsu_exc_tval);
    got_paddr = 64'(lsu_paddr);
    lsu_req   = 1'b0;
    check_value("lsu_exception_valid_o", exp_fault, 64'(got_exc));
    if (exp_fault[0]) begin
      check_value("lsu_exception_cause_o", exp_cause, got_cause);
      check_value("lsu_exception_tval_o", vaddr, got_tval);
    end else begin
      check_value("lsu_paddr_o", exp_paddr, got_paddr);
    end
    check_value("mem_req_o count", exp_reads, 64'(mem_reads - reads_before));
    // a translated access hits exactly when it needs no PTE reads
    if (mode[0]) begin
      check_value("lsu_dtlb_hit_o", 64'(exp_reads == 0), 64'(got_hit));
    end
    if (exp_reads == 0) begin
      check_value("lsu_valid_o latency", 64'd1, 64'(latency));
    end
    if (errors != errors_before) begin
      failed_tests++;
    end
    $display("test %0d vaddr %h mode %0h: %s", num, vaddr, mode,
             (errors == errors_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int ptr;
    int pairs;
    reset          = 1'b1;
    lsu_req        = 1'b0;
    lsu_vaddr      = '0;
    lsu_is_store   = 1'b0;
    en_translation = 1'b0;
    priv_lvl       = mmu_pkg::PRIV_S;
    sum            = 1'b0;
    satp_ppn       = 44'h100;
    flush_tlb      = 1'b0;
    mem_rvalid     = 1'b0;
    mem_rdata      = '0;
    mem_credit     = 1'b0;
    $readmemh("tests/mmu_tests.dat", vec);
    pairs = int'(vec[0]);
    for (int i = 0; i < pairs; i++) begin
      pt_mem[vec[1+2*i][55:0]] = vec[2+2*i];
    end
    ptr = 1 + 2*pairs;
    num_records = int'(vec[ptr]);
    ptr++;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    for (int r = 0; r < num_records; r++) begin
      run_record(ptr + r*REC_WORDS, r + 1);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             num_records, failed_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog sized from the record count
  initial begin
    #1;
    repeat (RESET_CYCLES + num_records*200) @(posedge clk);
    $display("timeout: the tests did not finish in %0d cycles", num_records*200);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: mmu_sv39_lite.f
verilog/mmu_pkg.sv
verilog/mmu_credit_counter.sv
verilog/mmu_tlb.sv
verilog/mmu_ptw.sv
verilog/mmu_lsu_check.sv
verilog/mmu_top.sv
tests/mmu_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the Sv39 load/store MMU

FILELIST = mmu_sv39_lite.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f $(FILELIST) --top-module mmu_tb -Mdir obj_dir

run: build
	./obj_dir/Vmmu_tb 2>&1 | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	verilator --lint-only -Wall -f $(FILELIST) --top-module mmu_top
	verilator --lint-only --timing -f $(FILELIST) --top-module mmu_tb

clean:
	rm -rf obj_dir $(LOG)

// File: tests/mmu_tests.dat
// word 0: number of page table words, then (address data) pairs
// then the record count, then records of:
// mode priv sum store vaddr exp_paddr exp_fault exp_cause exp_reads
// mode bit0 translation on, bit1 flush first, bit2 withhold credits
8
100000 40401
100008 100000C7
101000 40801
101008 1000C7
101010 1004C7
102008 800C7
102018 C00D7
102020 140047
// request records
F
// bypass load and store
0 1 0 0 7FFFFFF123 7FFFFFF123 0 0 0
0 1 0 1 1234 1234 0 0 0
// 4K walk, then reuse
1 1 0 0 1234 200234 0 0 3
1 1 0 1 1678 200678 0 0 0
// 2M and 1G leaves
1 1 0 0 205ABC 405ABC 0 0 2
1 1 0 0 40607010 40607010 0 0 1
// misaligned 2M leaf
1 1 0 0 400100 0 1 D 2
// invalid PTE on a store
1 1 0 1 2000 0 1 F 3
// U page from S, without and with SUM
1 1 0 0 3010 0 1 D 3
1 1 1 0 3010 300010 0 0 0
// store to a page with d clear
1 1 0 1 4020 0 1 F 3
// flush, the page walks again
3 1 0 0 1234 200234 0 0 3
// withheld credits
7 1 0 0 205000 405000 0 0 2
5 1 1 0 3008 300008 0 0 3
5 1 0 0 40000ABC 40000ABC 0 0 1
